// File: source/isa_pkg.sv
// --------------------
// instruction set definitions for the 16-bit core
// widths, opcodes, flag bit positions and branch condition codes
// import with isa_pkg::* in any block that decodes or executes
// --------------------
package isa_pkg;

    localparam int DATA_W    = 16;  // data and address width
    localparam int REG_IDX_W = 4;   // 16 architectural registers

    typedef logic [3:0] opcode_t;
    typedef logic [2:0] flags_t;    // {N, V, Z}

    // -------------------- opcodes
    localparam opcode_t OPC_ADD = 4'b0000;  // saturating add
    localparam opcode_t OPC_SUB = 4'b0001;  // saturating sub
    localparam opcode_t OPC_XOR = 4'b0010;
    localparam opcode_t OPC_LW  = 4'b1000;
    localparam opcode_t OPC_SW  = 4'b1001;
    localparam opcode_t OPC_LLB = 4'b1010;  // load low byte
    localparam opcode_t OPC_HLB = 4'b1011;  // load high byte
    localparam opcode_t OPC_B   = 4'b1100;  // conditional branch
    localparam opcode_t OPC_HLT = 4'b1111;

    // flag word bit indices
    localparam int FLAG_Z = 0;
    localparam int FLAG_V = 1;
    localparam int FLAG_N = 2;

    // -------------------- branch conditions in instr[11:9]
    localparam logic [2:0] COND_NE = 3'b000;
    localparam logic [2:0] COND_EQ = 3'b001;
    localparam logic [2:0] COND_GT = 3'b010;
    localparam logic [2:0] COND_LT = 3'b011;
    localparam logic [2:0] COND_GE = 3'b100;
    localparam logic [2:0] COND_LE = 3'b101;
    localparam logic [2:0] COND_OV = 3'b110;
    localparam logic [2:0] COND_UN = 3'b111;  // always taken

endpackage

// File: source/pipe_pkg.sv
// --------------------
// pipeline structure definitions
// stage payload structs, forwarding select, reset pc and pc step
// --------------------
package pipe_pkg;

    import isa_pkg::*;

    localparam logic [DATA_W-1:0] RESET_PC = 16'h0000;
    localparam logic [DATA_W-1:0] PC_STEP  = 16'h0002;  // one 16-bit instr

    // operand source for the alu inputs
    typedef enum logic [1:0] {
        FWD_RF     = 2'b00,  // register file value latched in ID
        FWD_MEM_WB = 2'b01,  // writeback result
        FWD_EX_MEM = 2'b10   // alu result one stage ahead
    } fwd_sel_t;

    // -------------------- stage payloads
    // all-zero payload is a bubble, every control bit low
    typedef struct packed {
        logic              valid;    // low after reset or flush
        logic [15:0]       instr;
        logic [DATA_W-1:0] pc_next;
    } if_id_t;

    typedef struct packed {
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 alu_src;
        logic                 flag_write;
        logic                 is_halt;
        opcode_t              alu_op;
        logic [REG_IDX_W-1:0] rs;
        logic [REG_IDX_W-1:0] rt;
        logic [REG_IDX_W-1:0] rd;
        logic [DATA_W-1:0]    rs_data;
        logic [DATA_W-1:0]    rt_data;
        logic [DATA_W-1:0]    imm;
    } id_ex_t;

    typedef struct packed {
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 is_halt;
        logic [DATA_W-1:0]    alu_result;  // also the data address
        logic [DATA_W-1:0]    store_data;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rt;          // store source, for mem-mem fwd
    } ex_mem_t;

    typedef struct packed {
        logic                 reg_write;
        logic                 mem_to_reg;
        logic [DATA_W-1:0]    alu_result;
        logic [DATA_W-1:0]    load_data;
        logic [REG_IDX_W-1:0] rd;
        logic                 is_halt;
    } mem_wb_t;

endpackage

// File: source/pipe_reg.sv
// --------------------
// generic stage register for one pipeline payload
// en holds on low, flush loads an all-zero bubble
// --------------------
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;  // bubble, all controls low
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// File: source/alu.sv
// --------------------
// EX stage arithmetic
// saturating add/sub with N V Z, xor, byte merges and memory address
// --------------------
`timescale 1ns/10ps

module alu import isa_pkg::*; (
    input  opcode_t           alu_op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] result,
    output flags_t            flags
);

    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic              add_ovf;
    logic              sub_ovf;
    logic              ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // signed overflow when result sign differs from a
    assign add_ovf = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
    assign sub_ovf = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);

    always_comb begin
        ovf = 1'b0;
        case (alu_op)
            OPC_ADD: begin
                ovf    = add_ovf;
                result = add_ovf ? (a[DATA_W-1] ? 16'h8000 : 16'h7fff) : sum;
            end
            OPC_SUB: begin
                ovf    = sub_ovf;
                result = sub_ovf ? (a[DATA_W-1] ? 16'h8000 : 16'h7fff) : diff;
            end
            OPC_XOR: result = a ^ b;
            OPC_LLB: result = {a[15:8], b[7:0]};   // keep high byte
            OPC_HLB: result = {b[7:0], a[7:0]};    // keep low byte
            OPC_LW, OPC_SW: result = {a[DATA_W-1:1], 1'b0} + b;  // word aligned base
            default: result = '0;
        endcase
    end

    // core decides which bits get written
    assign flags[FLAG_N] = result[DATA_W-1];
    assign flags[FLAG_V] = ovf;
    assign flags[FLAG_Z] = (result == '0);

endmodule

// File: source/register_file.sv
// --------------------
// 16 x 16-bit register file
// two read ports, one write port from WB, write data bypassed to reads
// --------------------
`timescale 1ns/10ps

module register_file import isa_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] rs,
    input  logic [REG_IDX_W-1:0] rt,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic                 wr_en,
    input  logic [DATA_W-1:0]    wr_data,
    output logic [DATA_W-1:0]    rs_data,
    output logic [DATA_W-1:0]    rt_data
);

    logic [DATA_W-1:0] regs [2**REG_IDX_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // same-cycle WB write seen by ID
    assign rs_data = (wr_en && wr_idx == rs) ? wr_data : regs[rs];
    assign rt_data = (wr_en && wr_idx == rt) ? wr_data : regs[rt];

endmodule

// File: source/decode_unit.sv
// --------------------
// ID stage decoder
// opcode to control bits, register selects and immediate
// --------------------
`timescale 1ns/10ps

module decode_unit import isa_pkg::*; (
    input  logic [15:0]          instr,
    output logic [REG_IDX_W-1:0] rs,
    output logic [REG_IDX_W-1:0] rt,
    output logic [REG_IDX_W-1:0] rd,
    output logic [DATA_W-1:0]    imm,
    output logic                 reg_write,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 mem_to_reg,
    output logic                 alu_src,
    output logic                 flag_write,
    output logic                 is_branch,
    output logic                 is_halt,
    output opcode_t              alu_op,
    output logic [2:0]           cond
);

    opcode_t opc;
    logic    byte_ld;  // llb or hlb

    assign opc     = instr[15:12];
    assign alu_op  = opc;
    assign cond    = instr[11:9];
    assign byte_ld = (opc == OPC_LLB) || (opc == OPC_HLB);

    // byte loads read the old rd, stores read data from rd field
    assign rs = byte_ld ? instr[11:8] : instr[7:4];
    assign rt = (opc == OPC_SW) ? instr[11:8] : instr[3:0];
    assign rd = instr[11:8];

    // word offset for lw/sw, imm8 for byte loads
    assign imm = (opc == OPC_LW || opc == OPC_SW) ?
                 {{(DATA_W-5){instr[3]}}, instr[3:0], 1'b0} :
                 {{(DATA_W-8){1'b0}}, instr[7:0]};

    always_comb begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        flag_write = 1'b0;
        is_branch  = 1'b0;
        is_halt    = 1'b0;
        case (opc)
            OPC_ADD, OPC_SUB, OPC_XOR: begin
                reg_write  = 1'b1;
                flag_write = 1'b1;
            end
            OPC_LW: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;  // base + offset
            end
            OPC_SW: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            OPC_LLB, OPC_HLB: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OPC_B:   is_branch = 1'b1;
            OPC_HLT: is_halt   = 1'b1;
            default: ;  // shifts, rotate, paddsb, red fall through as no-ops
        endcase
    end

endmodule

// File: source/hazard_unit.sv
// --------------------
// branch resolution and hazard detection in ID
// raises stall for load-use and flag dependences, flush on taken branch
// --------------------
`timescale 1ns/10ps

module hazard_unit import isa_pkg::*; (
    input  logic                 is_branch,
    input  logic [2:0]           cond,
    input  flags_t               flags,
    input  logic [8:0]           branch_off,
    input  logic [DATA_W-1:0]    pc_next,
    input  logic [REG_IDX_W-1:0] if_id_rs,
    input  logic [REG_IDX_W-1:0] if_id_rt,
    input  logic                 if_id_uses_rt,
    input  logic                 id_ex_mem_read,
    input  logic                 id_ex_flag_write,
    input  logic [REG_IDX_W-1:0] id_ex_rd,
    output logic                 stall,
    output logic                 flush,
    output logic [DATA_W-1:0]    branch_target
);

    logic cond_met;
    logic load_use;
    logic flag_wait;

    // -------------------- condition check
    always_comb begin
        case (cond)
            COND_NE: cond_met = ~flags[FLAG_Z];
            COND_EQ: cond_met = flags[FLAG_Z];
            COND_GT: cond_met = ~flags[FLAG_Z] & ~flags[FLAG_N];
            COND_LT: cond_met = flags[FLAG_N];
            COND_GE: cond_met = flags[FLAG_Z] | ~flags[FLAG_N];
            COND_LE: cond_met = flags[FLAG_N] | flags[FLAG_Z];
            COND_OV: cond_met = flags[FLAG_V];
            COND_UN: cond_met = 1'b1;
            default: cond_met = 1'b0;
        endcase
    end

    // pc+2 plus signed word offset
    assign branch_target = pc_next + {{(DATA_W-10){branch_off[8]}}, branch_off, 1'b0};

    // -------------------- stalls
    // lw result not ready until WB, store data of SW is fixed up in MEM instead
    assign load_use  = id_ex_mem_read &&
                       ((id_ex_rd == if_id_rs) || (if_id_uses_rt && id_ex_rd == if_id_rt));
    assign flag_wait = is_branch & id_ex_flag_write;  // flags land at end of EX

    assign stall = load_use | flag_wait;
    assign flush = is_branch & cond_met & ~stall;  // never together with stall

endmodule

// File: source/forward_unit.sv
// --------------------
// forwarding selects for EX operands and MEM store data
// EX/MEM wins over MEM/WB when both match
// --------------------
`timescale 1ns/10ps

module forward_unit import isa_pkg::*; import pipe_pkg::*; (
    input  logic [REG_IDX_W-1:0] id_ex_rs,
    input  logic [REG_IDX_W-1:0] id_ex_rt,
    input  logic [REG_IDX_W-1:0] ex_mem_rd,
    input  logic [REG_IDX_W-1:0] mem_wb_rd,
    input  logic                 ex_mem_reg_write,
    input  logic                 mem_wb_reg_write,
    input  logic [REG_IDX_W-1:0] ex_mem_rt_src,
    output fwd_sel_t             fwd_a,
    output fwd_sel_t             fwd_b,
    output logic                 fwd_store
);

    // -------------------- alu operands
    assign fwd_a = (ex_mem_reg_write && ex_mem_rd == id_ex_rs) ? FWD_EX_MEM :
                   (mem_wb_reg_write && mem_wb_rd == id_ex_rs) ? FWD_MEM_WB : FWD_RF;

    assign fwd_b = (ex_mem_reg_write && ex_mem_rd == id_ex_rt) ? FWD_EX_MEM :
                   (mem_wb_reg_write && mem_wb_rd == id_ex_rt) ? FWD_MEM_WB : FWD_RF;

    // mem-mem path for lw directly before sw of the same reg
    assign fwd_store = mem_wb_reg_write && (mem_wb_rd == ex_mem_rt_src);

endmodule

// File: source/cpu_core.sv
// --------------------
// five-stage pipelined 16-bit core with IF ID EX MEM WB stages
// instruction and data memories live outside, both read combinationally
// hlt rises once an HLT reaches WB and holds until reset
// --------------------
`timescale 1ns/10ps

module cpu_core import isa_pkg::*; import pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [15:0]       instr,     // imem data at pc
    input  logic [DATA_W-1:0] d_rdata,   // dmem data at d_addr
    output logic [DATA_W-1:0] pc,
    output logic              hlt,
    output logic [DATA_W-1:0] d_addr,
    output logic [DATA_W-1:0] d_wdata,
    output logic              d_wen,
    output logic              d_ren
);

    // -------------------- declarations
    logic [DATA_W-1:0]    pc_plus, pc_nxt, branch_target;
    logic                 if_hlt, stall, flush;
    if_id_t               if_id_d, if_id_q;
    id_ex_t               id_ex_d, id_ex_q;
    ex_mem_t              ex_mem_d, ex_mem_q;
    mem_wb_t              mem_wb_d, mem_wb_q;

    logic [REG_IDX_W-1:0] rs, rt, rd;
    logic [DATA_W-1:0]    imm, rs_data, rt_data;
    logic                 reg_write, mem_read, mem_write, mem_to_reg;
    logic                 alu_src, flag_write, is_branch, is_halt;
    logic                 v;          // ID slot holds a real instr
    opcode_t              alu_op;
    logic [2:0]           cond;

    flags_t               flag_q, alu_flags;
    fwd_sel_t             fwd_a, fwd_b;
    logic                 fwd_store;
    logic [DATA_W-1:0]    fwd_a_data, fwd_b_data, alu_b, alu_result, wb_data;

    // -------------------- IF
    assign pc_plus = pc + PC_STEP;
    assign if_hlt  = (instr[15:12] == OPC_HLT);  // park on halt, refetch it

    assign pc_nxt = flush            ? branch_target :
                    (stall | if_hlt) ? pc : pc_plus;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) pc <= RESET_PC;
        else        pc <= pc_nxt;
    end

    assign if_id_d = '{valid: 1'b1, instr: instr, pc_next: pc_plus};

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst_n(rst_n),
        .en(~stall), .flush(flush),   // hold on stall, kill on taken branch
        .d(if_id_d), .q(if_id_q)
    );

    // -------------------- ID
    assign v = if_id_q.valid;

    decode_unit u_decode (
        .instr(if_id_q.instr),
        .rs(rs), .rt(rt), .rd(rd), .imm(imm),
        .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .mem_to_reg(mem_to_reg), .alu_src(alu_src), .flag_write(flag_write),
        .is_branch(is_branch), .is_halt(is_halt),
        .alu_op(alu_op), .cond(cond)
    );

    register_file u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rs(rs), .rt(rt),
        .wr_idx(mem_wb_q.rd), .wr_en(mem_wb_q.reg_write), .wr_data(wb_data),
        .rs_data(rs_data), .rt_data(rt_data)
    );

    hazard_unit u_hazard (
        .is_branch(is_branch & v),
        .cond(cond), .flags(flag_q),
        .branch_off(if_id_q.instr[8:0]), .pc_next(if_id_q.pc_next),
        .if_id_rs(rs), .if_id_rt(rt),
        .if_id_uses_rt(reg_write & ~alu_src),   // add, sub, xor
        .id_ex_mem_read(id_ex_q.mem_read), .id_ex_flag_write(id_ex_q.flag_write),
        .id_ex_rd(id_ex_q.rd),
        .stall(stall), .flush(flush), .branch_target(branch_target)
    );

    // bubble after reset or flush carries no controls
    always_comb begin
        id_ex_d            = '0;
        id_ex_d.reg_write  = reg_write & v;
        id_ex_d.mem_read   = mem_read & v;
        id_ex_d.mem_write  = mem_write & v;
        id_ex_d.mem_to_reg = mem_to_reg & v;
        id_ex_d.alu_src    = alu_src;
        id_ex_d.flag_write = flag_write & v;
        id_ex_d.is_halt    = is_halt & v;
        id_ex_d.alu_op     = alu_op;
        id_ex_d.rs         = rs;
        id_ex_d.rt         = rt;
        id_ex_d.rd         = rd;
        id_ex_d.rs_data    = rs_data;
        id_ex_d.rt_data    = rt_data;
        id_ex_d.imm        = imm;
    end

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n),
        .en(1'b1), .flush(stall),     // stall inserts a bubble
        .d(id_ex_d), .q(id_ex_q)
    );

    // -------------------- EX
    forward_unit u_fwd (
        .id_ex_rs(id_ex_q.rs), .id_ex_rt(id_ex_q.rt),
        .ex_mem_rd(ex_mem_q.rd), .mem_wb_rd(mem_wb_q.rd),
        .ex_mem_reg_write(ex_mem_q.reg_write), .mem_wb_reg_write(mem_wb_q.reg_write),
        .ex_mem_rt_src(ex_mem_q.rt),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store)
    );

    assign fwd_a_data = (fwd_a == FWD_EX_MEM) ? ex_mem_q.alu_result :
                        (fwd_a == FWD_MEM_WB) ? wb_data : id_ex_q.rs_data;
    assign fwd_b_data = (fwd_b == FWD_EX_MEM) ? ex_mem_q.alu_result :
                        (fwd_b == FWD_MEM_WB) ? wb_data : id_ex_q.rt_data;
    assign alu_b      = id_ex_q.alu_src ? id_ex_q.imm : fwd_b_data;

    alu u_alu (
        .alu_op(id_ex_q.alu_op),
        .a(fwd_a_data), .b(alu_b),
        .result(alu_result), .flags(alu_flags)
    );

    // xor touches only Z of the flag register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_q <= '0;
        end else if (id_ex_q.flag_write) begin
            flag_q[FLAG_Z] <= alu_flags[FLAG_Z];
            if (id_ex_q.alu_op != OPC_XOR) begin
                flag_q[FLAG_N] <= alu_flags[FLAG_N];
                flag_q[FLAG_V] <= alu_flags[FLAG_V];
            end
        end
    end

    assign ex_mem_d = '{reg_write:  id_ex_q.reg_write,  mem_read: id_ex_q.mem_read,
                        mem_write:  id_ex_q.mem_write,  mem_to_reg: id_ex_q.mem_to_reg,
                        is_halt:    id_ex_q.is_halt,    alu_result: alu_result,
                        store_data: fwd_b_data,         rd: id_ex_q.rd,
                        rt:         id_ex_q.rt};

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst_n(rst_n),
        .en(1'b1), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // -------------------- MEM
    assign d_addr  = ex_mem_q.alu_result;
    assign d_wdata = fwd_store ? wb_data : ex_mem_q.store_data;  // lw then sw fixup
    assign d_wen   = ex_mem_q.mem_write;
    assign d_ren   = ex_mem_q.mem_read;

    assign mem_wb_d = '{reg_write:  ex_mem_q.reg_write, mem_to_reg: ex_mem_q.mem_to_reg,
                        alu_result: ex_mem_q.alu_result, load_data: d_rdata,
                        rd:         ex_mem_q.rd,        is_halt: ex_mem_q.is_halt};

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst_n(rst_n),
        .en(1'b1), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    // -------------------- WB
    assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
    assign hlt     = mem_wb_q.is_halt;  // refetched HLTs keep this high

endmodule

// File: bench/tb_programs.svh
// --------------------
// program table for the core testbench
// one row per program with code words, stores expected in order and final pc
// a loaded store expects the ram word at src plus an addend, clamped
// --------------------

localparam int N_ROWS = 4;

typedef struct packed {
    logic [15:0] addr;
    logic [15:0] data;      // value, or addend for a loaded store
    logic        from_ram;
    logic [15:0] src;       // byte address the loaded word came from
} exp_store_t;

string       row_name;
logic [15:0] prog   [$];    // code words from address 0
exp_store_t  exp_st [$];
logic [15:0] end_pc;        // address of the HLT that stops the row

function automatic exp_store_t plain_store(input logic [15:0] addr,
                                           input logic [15:0] data);
    return '{addr: addr, data: data, from_ram: 1'b0, src: 16'h0000};
endfunction

function automatic exp_store_t loaded_store(input logic [15:0] addr, input logic [15:0] src,
                                            input logic [15:0] addend);
    return '{addr: addr, data: addend, from_ram: 1'b1, src: src};
endfunction

task automatic select_row(input int r);
    case (r)
        0: begin  // byte loads, saturation, ex-ex and mem-ex forwarding
            row_name = "alu_forwarding";
            prog = '{16'hA134, 16'hB112, 16'hA2FF, 16'hB27F, 16'hA980, 16'h0312, 16'h9390,
                     16'h1412, 16'h1542, 16'h2651, 16'h9491, 16'h9592, 16'h9693, 16'h0755,
                     16'h0871, 16'h9894, 16'h2A12, 16'h9795, 16'h9A96, 16'hF000};
            exp_st = '{plain_store(16'h0080, 16'h7FFF), plain_store(16'h0082, 16'h9235),
                       plain_store(16'h0084, 16'h8000), plain_store(16'h0086, 16'h9234),
                       plain_store(16'h0088, 16'h9234), plain_store(16'h008A, 16'h8000),
                       plain_store(16'h008C, 16'h6DCB)};
            end_pc = 16'h0026;
        end
        1: begin  // lw then dependent add on rs and rt, lw then sw of same reg
            row_name = "load_use";
            prog = '{16'hA140, 16'hA205, 16'hA9A0, 16'h8312, 16'h0432, 16'h9490,
                     16'h8513, 16'h9591, 16'h861F, 16'h0726, 16'h9792, 16'hF000};
            exp_st = '{loaded_store(16'h00A0, 16'h0044, 16'h0005),
                       loaded_store(16'h00A2, 16'h0046, 16'h0000),
                       loaded_store(16'h00A4, 16'h003E, 16'h0005)};
            end_pc = 16'h0016;
        end
        2: begin  // sub or xor right before B, taken and not taken, flushed HLT
            row_name = "branching";
            prog = '{16'hA105, 16'hA203, 16'hA9C0, 16'h1312, 16'hC401, 16'h9190, 16'h9391,
                     16'h1421, 16'hC201, 16'h9492, 16'h1511, 16'hC002, 16'hCA01, 16'h9193,
                     16'hB680, 16'h1761, 16'hCC02, 16'hF000, 16'h9194, 16'h9795, 16'h2811,
                     16'hC601, 16'h9196, 16'h9897, 16'hCE01, 16'h9190, 16'hF000};
            exp_st = '{plain_store(16'h00C2, 16'h0002), plain_store(16'h00C4, 16'hFFFE),
                       plain_store(16'h00CA, 16'h8000), plain_store(16'h00CE, 16'h0000)};
            end_pc = 16'h0034;
        end
        default: begin  // stores behind the HLT never issue
            row_name = "halt";
            prog = '{16'hA177, 16'hA910, 16'h9190, 16'hF000, 16'h9191, 16'h9192};
            exp_st = '{plain_store(16'h0010, 16'h0077)};
            end_pc = 16'h0006;
        end
    endcase
endtask

// File: bench/cpu_core_tb.sv
// --------------------
// testbench for the pipelined core
// runs every program of the table from reset to halt
// models the instruction rom and data ram, checks stores, pc and hlt
// --------------------
`timescale 1ns/10ps

module cpu_core_tb;

    localparam int MEM_WORDS   = 256;
    localparam int TAIL_CYCLES = 5;     // watched after hlt for stray stores

    logic        clk;
    logic        rst_n;
    logic [15:0] instr   = '0;
    logic [15:0] d_rdata = '0;
    logic [15:0] pc;
    logic        hlt;
    logic [15:0] d_addr;
    logic [15:0] d_wdata;
    logic        d_wen;
    logic        d_ren;

    logic [15:0] rom      [MEM_WORDS];
    logic [15:0] ram      [MEM_WORDS];
    logic [15:0] ram_init [MEM_WORDS];  // image every row starts from
    logic [31:0] st_log   [$];          // {addr, data} per store, in order
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          errors      = 0;
    int          rows_failed = 0;

    `include "tb_programs.svh"

    cpu_core u_cpu_core (
        .clk(clk), .rst_n(rst_n), .instr(instr), .d_rdata(d_rdata),
        .pc(pc), .hlt(hlt), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_wen(d_wen), .d_ren(d_ren)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // -------------------- memory models
    // both read combinationally, presented 1 ns after the edge
    // ram drives data only while the read strobe is up
    always @(posedge clk) begin
        #1;
        instr   = rom[pc[8:1]];
        d_rdata = d_ren ? ram[d_addr[8:1]] : 16'h0000;
    end

    // stores sampled mid-cycle, ram restored while in reset
    always @(negedge clk) begin
        if (!rst_n) begin
            ram = ram_init;
            st_log.delete();
        end else if (d_wen) begin
            st_log.push_back({d_addr, d_wdata});
            ram[d_addr[8:1]] = d_wdata;
        end
    end

    // watchdog over the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the core did not halt within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // -------------------- reference values
    // signed add clamped to the 16-bit range
    function automatic logic [15:0] sat_add(input logic [15:0] a, input logic [15:0] b);
        int s;
        s = int'($signed(a)) + int'($signed(b));
        if (s > 32767) return 16'h7fff;
        else if (s < -32768) return 16'h8000;
        else return s[15:0];
    endfunction

    function automatic logic [15:0] expected_data(input exp_store_t e);
        if (e.from_ram) return sat_add(ram_init[e.src[8:1]], e.data);
        else return e.data;
    endfunction

    // -------------------- one table row
    task automatic run_row(input int r);
        int          fails;
        logic [15:0] want;
        fails = 0;
        select_row(r);
        rst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = (i < prog.size()) ? prog[i] : {8'hf0, 8'(i)};  // HLT past the end
        end
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        #1;
        if (pc !== 16'h0000 || hlt !== 1'b0 || d_wen !== 1'b0 || d_ren !== 1'b0) begin
            $display("error at %0t: %s after reset pc=%h hlt=%b d_wen=%b d_ren=%b",
                     $time, row_name, pc, hlt, d_wen, d_ren);
            fails++;
        end
        while (hlt !== 1'b1) @(negedge clk);
        repeat (TAIL_CYCLES) @(negedge clk);
        if (st_log.size() != exp_st.size()) begin
            $display("error at %0t: %s saw %0d stores, expected %0d",
                     $time, row_name, st_log.size(), exp_st.size());
            fails++;
        end
        for (int k = 0; k < exp_st.size() && k < st_log.size(); k++) begin
            want = expected_data(exp_st[k]);
            if (st_log[k] !== {exp_st[k].addr, want}) begin
                $display("error at %0t: %s store %0d wrote %h to %h, expected %h to %h",
                         $time, row_name, k, st_log[k][15:0], st_log[k][31:16],
                         want, exp_st[k].addr);
                fails++;
            end
        end
        if (pc !== end_pc || hlt !== 1'b1) begin
            $display("error at %0t: %s halted with pc=%h hlt=%b, expected pc=%h",
                     $time, row_name, pc, hlt, end_pc);
            fails++;
        end
        $display("row %0d %s: %s, %0d stores", r, row_name,
                 (fails == 0) ? "ok" : "failed", st_log.size());
        errors += fails;
        if (fails != 0) rows_failed++;
    endtask

    // -------------------- main sequence
    initial begin
        int limit;
        limit = 0;
        rst_n = 1'b0;
        void'($urandom(39));
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram_init[i] = 16'($urandom);
        end
        // 4 cycles per instruction plus 20 per row
        for (int r = 0; r < N_ROWS; r++) begin
            select_row(r);
            limit += 4 * prog.size() + 20;
        end
        cycle_limit = limit;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("rows run %0d, rows failed %0d, failed checks %0d",
                 N_ROWS, rows_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: cpu_core.f
+incdir+bench
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_reg.sv
source/alu.sv
source/register_file.sv
source/decode_unit.sv
source/hazard_unit.sv
source/forward_unit.sv
source/cpu_core.sv
bench/cpu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the core testbench with verilator and runs it
# the run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    --top-module cpu_core_tb -f cpu_core.f \
    -Mdir obj_dir -o cpu_core_sim > build.log 2>&1 \
    && ./obj_dir/cpu_core_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
